/* opx_macros.svh */
// Operand path width macros
// Data width, register address width and register count shared by every block

`ifndef OPX_MACROS_SVH
`define OPX_MACROS_SVH

// Operand and result width in bits
`define OPX_DATA_WIDTH 32

// Register number width
`define OPX_REG_ADDR_WIDTH 3

// Number of architectural registers
// Must match 2**OPX_REG_ADDR_WIDTH
`define OPX_REG_COUNT 8

`endif

/* opx_isa_pkg.sv */
// Instruction set types for the operand path
// Data word, register number and ALU operation encoding

`include "opx_macros.svh"

package opx_isa_pkg;

	// One operand or result word
	typedef logic [`OPX_DATA_WIDTH-1:0] data_t;

	// Register number
	typedef logic [`OPX_REG_ADDR_WIDTH-1:0] reg_addr_t;

	// ALU operations
	// Shifts take their amount from the low bits of operand B
	typedef enum logic [2:0] {
		alu_add    = 3'd0,
		alu_sub    = 3'd1,
		alu_and    = 3'd2,
		alu_or     = 3'd3,
		alu_xor    = 3'd4,
		alu_sll    = 3'd5,
		alu_srl    = 3'd6,
		alu_pass_b = 3'd7
	} alu_op_e;

endpackage

/* opx_ctrl_pkg.sv */
// Pipeline control types for the operand path
// Operand source select shared by decode and the operand muxes

package opx_ctrl_pkg;

	// Where an operand is taken from
	// Register file is the fallback when no hazard is seen
	// Only operand B may take the immediate
	typedef enum logic [1:0] {
		opnd_rf      = 2'd0,
		opnd_imm     = 2'd1,
		// Result of the instruction now in execute
		opnd_ex_forw = 2'd2,
		// Result held in the writeback register
		opnd_wb_forw = 2'd3
	} opnd_sel_e;

endpackage

/* opx_decode.sv */
// Decode stage
// Holds the incoming instruction and picks the source of each operand

`timescale 1ns/1ps

module opx_decode (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      id_freeze,
	input  logic                      ex_freeze,
	input  logic                      in_valid,
	input  opx_isa_pkg::alu_op_e      in_op,
	input  logic                      in_use_imm,
	input  opx_isa_pkg::reg_addr_t    in_rd,
	input  opx_isa_pkg::reg_addr_t    in_ra,
	input  opx_isa_pkg::reg_addr_t    in_rb,
	input  opx_isa_pkg::data_t        in_imm,
	input  logic                      ex_valid,
	input  opx_isa_pkg::reg_addr_t    ex_rd,
	input  logic                      wb_valid,
	input  opx_isa_pkg::reg_addr_t    wb_rd,
	output opx_isa_pkg::reg_addr_t    ra,
	output opx_isa_pkg::reg_addr_t    rb,
	output opx_ctrl_pkg::opnd_sel_e   sel_a,
	output opx_ctrl_pkg::opnd_sel_e   sel_b,
	output opx_isa_pkg::data_t        simm,
	output logic                      id_valid,
	output opx_isa_pkg::alu_op_e      id_op,
	output opx_isa_pkg::reg_addr_t    id_rd
);

	// Immediate flag of the held instruction
	logic id_use_imm;

	// Hazard hits per source
	logic ex_hit_a;
	logic ex_hit_b;
	logic wb_hit_a;
	logic wb_hit_b;

	////////////////////////////////////////////////////////////////////////////
	// Decode register
	////////////////////////////////////////////////////////////////////////////

	// Hold under either freeze
	// ex_freeze always comes with id_freeze but is honoured on its own too
	always_ff @(posedge clk) begin
		if (rst) begin
			id_valid   <= 1'b0;
			id_op      <= opx_isa_pkg::alu_add;
			id_use_imm <= 1'b0;
			id_rd      <= '0;
			ra         <= '0;
			rb         <= '0;
			simm       <= '0;
		end else if (!id_freeze && !ex_freeze) begin
			id_valid   <= in_valid;
			id_op      <= in_op;
			id_use_imm <= in_use_imm;
			id_rd      <= in_rd;
			ra         <= in_ra;
			rb         <= in_rb;
			simm       <= in_imm;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Hazard comparison
	////////////////////////////////////////////////////////////////////////////

	// Only a valid producer counts
	assign ex_hit_a = ex_valid && (ex_rd == ra);
	assign ex_hit_b = ex_valid && (ex_rd == rb);
	assign wb_hit_a = wb_valid && (wb_rd == ra);
	assign wb_hit_b = wb_valid && (wb_rd == rb);

	// Nearest producer wins, so execute beats writeback
	always_comb begin
		if (ex_hit_a)
			sel_a = opx_ctrl_pkg::opnd_ex_forw;
		else if (wb_hit_a)
			sel_a = opx_ctrl_pkg::opnd_wb_forw;
		else
			sel_a = opx_ctrl_pkg::opnd_rf;
	end

	// Immediate overrides any hazard on the B source
	always_comb begin
		if (id_use_imm)
			sel_b = opx_ctrl_pkg::opnd_imm;
		else if (ex_hit_b)
			sel_b = opx_ctrl_pkg::opnd_ex_forw;
		else if (wb_hit_b)
			sel_b = opx_ctrl_pkg::opnd_wb_forw;
		else
			sel_b = opx_ctrl_pkg::opnd_rf;
	end

endmodule

/* opx_regfile.sv */
// Register file
// Two combinational reads and one write, with same-cycle write-through

`timescale 1ns/1ps

`include "opx_macros.svh"

module opx_regfile (
	input  logic                      clk,
	input  logic                      rst,
	input  opx_isa_pkg::reg_addr_t    ra,
	input  opx_isa_pkg::reg_addr_t    rb,
	input  logic                      wb_we,
	input  opx_isa_pkg::reg_addr_t    wb_rd,
	input  opx_isa_pkg::data_t        wb_data,
	output opx_isa_pkg::data_t        rf_data_a,
	output opx_isa_pkg::data_t        rf_data_b
);

	// Register storage
	opx_isa_pkg::data_t regs [`OPX_REG_COUNT];

	////////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////////

	// All registers start at zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `OPX_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wb_we) begin
			regs[wb_rd] <= wb_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////////////////////

	// A write in flight to the same register is returned directly
	assign rf_data_a = (wb_we && (wb_rd == ra)) ? wb_data : regs[ra];
	assign rf_data_b = (wb_we && (wb_rd == rb)) ? wb_data : regs[rb];

endmodule

/* opx_operand_mux.sv */
// Operand muxes and operand registers
// Forwards execute, writeback or immediate values and saves them across freezes

`timescale 1ns/1ps

module opx_operand_mux (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      id_freeze,
	input  logic                      ex_freeze,
	input  opx_isa_pkg::data_t        rf_data_a,
	input  opx_isa_pkg::data_t        rf_data_b,
	input  opx_isa_pkg::data_t        ex_forw,
	input  opx_isa_pkg::data_t        wb_forw,
	input  opx_isa_pkg::data_t        simm,
	input  opx_ctrl_pkg::opnd_sel_e   sel_a,
	input  opx_ctrl_pkg::opnd_sel_e   sel_b,
	output opx_isa_pkg::data_t        operand_a,
	output opx_isa_pkg::data_t        operand_b,
	output opx_isa_pkg::data_t        muxed_a,
	output opx_isa_pkg::data_t        muxed_b
);

	// Set once operands are captured under id_freeze alone
	logic saved_a;
	logic saved_b;

	// Operand register load enables
	logic load_a;
	logic load_b;

	// Source select for operand B
	function automatic opx_isa_pkg::data_t pick_operand(
		input opx_ctrl_pkg::opnd_sel_e sel,
		input opx_isa_pkg::data_t      rf,
		input opx_isa_pkg::data_t      imm,
		input opx_isa_pkg::data_t      ex,
		input opx_isa_pkg::data_t      wb
	);
		case (sel)
			opx_ctrl_pkg::opnd_imm:     pick_operand = imm;
			opx_ctrl_pkg::opnd_ex_forw: pick_operand = ex;
			opx_ctrl_pkg::opnd_wb_forw: pick_operand = wb;
			default:                    pick_operand = rf;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Forwarding muxes
	////////////////////////////////////////////////////////////////////////////

	// Operand A has no immediate path
	assign muxed_a = (sel_a == opx_ctrl_pkg::opnd_ex_forw) ? ex_forw :
		(sel_a == opx_ctrl_pkg::opnd_wb_forw) ? wb_forw : rf_data_a;
	assign muxed_b = pick_operand(sel_b, rf_data_b, simm, ex_forw, wb_forw);

	////////////////////////////////////////////////////////////////////////////
	// Operand registers
	////////////////////////////////////////////////////////////////////////////

	// Load whenever execute moves and no saved copy is pending
	assign load_a = !ex_freeze && !saved_a;
	assign load_b = !ex_freeze && !saved_b;

	// Loading under id_freeze marks the copy as saved
	// Saved copy is released once both freezes drop
	always_ff @(posedge clk) begin
		if (rst) begin
			operand_a <= '0;
			saved_a   <= 1'b0;
		end else if (load_a) begin
			operand_a <= muxed_a;
			saved_a   <= id_freeze;
		end else if (!ex_freeze && !id_freeze) begin
			saved_a   <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			operand_b <= '0;
			saved_b   <= 1'b0;
		end else if (load_b) begin
			operand_b <= muxed_b;
			saved_b   <= id_freeze;
		end else if (!ex_freeze && !id_freeze) begin
			saved_b   <= 1'b0;
		end
	end

endmodule

/* opx_execute.sv */
// Execute stage
// Control register, eight-operation ALU and the writeback register

`timescale 1ns/1ps

`include "opx_macros.svh"

module opx_execute (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      id_freeze,
	input  logic                      ex_freeze,
	input  logic                      id_valid,
	input  opx_isa_pkg::alu_op_e      id_op,
	input  opx_isa_pkg::reg_addr_t    id_rd,
	input  opx_isa_pkg::data_t        operand_a,
	input  opx_isa_pkg::data_t        operand_b,
	output logic                      ex_valid,
	output opx_isa_pkg::reg_addr_t    ex_rd,
	output opx_isa_pkg::data_t        ex_forw,
	output logic                      wb_valid,
	output opx_isa_pkg::reg_addr_t    wb_rd,
	output opx_isa_pkg::data_t        wb_forw,
	output logic                      wb_we,
	output opx_isa_pkg::data_t        wb_data
);

	// Shift amount width for the data word
	localparam int shamt_width = $clog2(`OPX_DATA_WIDTH);

	// Operation of the instruction in execute
	opx_isa_pkg::alu_op_e ex_op;

	// Writeback result register
	opx_isa_pkg::data_t wb_result;

	// Shift amount from operand B
	logic [shamt_width-1:0] shamt;

	////////////////////////////////////////////////////////////////////////////
	// Execute control register
	////////////////////////////////////////////////////////////////////////////

	// id_freeze alone inserts a bubble, op and rd are don't care then
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
			ex_op    <= opx_isa_pkg::alu_add;
			ex_rd    <= '0;
		end else if (!ex_freeze) begin
			ex_valid <= id_valid && !id_freeze;
			ex_op    <= id_op;
			ex_rd    <= id_rd;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////////////

	assign shamt = operand_b[shamt_width-1:0];

	// Result doubles as the execute forward
	always_comb begin
		case (ex_op)
			opx_isa_pkg::alu_add:    ex_forw = operand_a + operand_b;
			opx_isa_pkg::alu_sub:    ex_forw = operand_a - operand_b;
			opx_isa_pkg::alu_and:    ex_forw = operand_a & operand_b;
			opx_isa_pkg::alu_or:     ex_forw = operand_a | operand_b;
			opx_isa_pkg::alu_xor:    ex_forw = operand_a ^ operand_b;
			opx_isa_pkg::alu_sll:    ex_forw = operand_a << shamt;
			opx_isa_pkg::alu_srl:    ex_forw = operand_a >> shamt;
			default:                 ex_forw = operand_b;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Writeback register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid  <= 1'b0;
			wb_rd     <= '0;
			wb_result <= '0;
		end else if (!ex_freeze) begin
			wb_valid  <= ex_valid;
			wb_rd     <= ex_rd;
			wb_result <= ex_forw;
		end
	end

	// Write only on a moving cycle so each result lands once
	assign wb_we   = wb_valid && !ex_freeze;
	assign wb_forw = wb_result;
	assign wb_data = wb_result;

endmodule

/* opx_core.sv */
// Operand path top level
// Connects decode, register file, operand muxes and execute

`timescale 1ns/1ps

module opx_core (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      id_freeze,
	input  logic                      ex_freeze,
	input  logic                      in_valid,
	input  opx_isa_pkg::alu_op_e      in_op,
	input  logic                      in_use_imm,
	input  opx_isa_pkg::reg_addr_t    in_rd,
	input  opx_isa_pkg::reg_addr_t    in_ra,
	input  opx_isa_pkg::reg_addr_t    in_rb,
	input  opx_isa_pkg::data_t        in_imm,
	output logic                      wb_we,
	output opx_isa_pkg::reg_addr_t    wb_rd,
	output opx_isa_pkg::data_t        wb_data
);

	// Decode to register file and operand muxes
	opx_isa_pkg::reg_addr_t  ra;
	opx_isa_pkg::reg_addr_t  rb;
	opx_isa_pkg::data_t      rf_data_a;
	opx_isa_pkg::data_t      rf_data_b;
	opx_ctrl_pkg::opnd_sel_e sel_a;
	opx_ctrl_pkg::opnd_sel_e sel_b;
	opx_isa_pkg::data_t      simm;

	// Decode to execute
	logic                    id_valid;
	opx_isa_pkg::alu_op_e    id_op;
	opx_isa_pkg::reg_addr_t  id_rd;

	// Execute state seen by decode and the muxes
	logic                    ex_valid;
	opx_isa_pkg::reg_addr_t  ex_rd;
	logic                    wb_valid;
	opx_isa_pkg::data_t      ex_forw;
	opx_isa_pkg::data_t      wb_forw;

	// Operand registers and mux outputs
	opx_isa_pkg::data_t      operand_a;
	opx_isa_pkg::data_t      operand_b;
	opx_isa_pkg::data_t      muxed_a;
	opx_isa_pkg::data_t      muxed_b;

	opx_decode u_decode (.*);

	opx_regfile u_regfile (.*);

	opx_operand_mux u_operand_mux (.*);

	opx_execute u_execute (.*);

endmodule

/* opx_assert.sv */
// Operand path rule checks
// Freeze, forwarding and writeback properties bound into the top level

`timescale 1ns/1ps

module opx_assert (
	input logic                    clk,
	input logic                    rst,
	input logic                    id_freeze,
	input logic                    ex_freeze,
	input logic                    in_valid,
	input logic                    wb_we,
	input opx_isa_pkg::data_t      wb_data,
	input opx_ctrl_pkg::opnd_sel_e sel_a,
	input opx_ctrl_pkg::opnd_sel_e sel_b,
	input opx_isa_pkg::data_t      muxed_a,
	input opx_isa_pkg::data_t      muxed_b,
	input opx_isa_pkg::data_t      rf_data_a,
	input opx_isa_pkg::data_t      rf_data_b,
	input opx_isa_pkg::data_t      simm,
	input opx_isa_pkg::data_t      ex_forw,
	input opx_isa_pkg::data_t      wb_forw,
	input opx_isa_pkg::data_t      operand_a,
	input opx_isa_pkg::data_t      operand_b
);

	////////////////////////////////////////////////////////////////////////////
	// Writeback and freeze rules
	////////////////////////////////////////////////////////////////////////////

	// Nothing written right after reset
	a_reset_quiet: assert property (@(posedge clk) rst |=> !wb_we)
		else $error("wb_we high right after reset");

	// Undisturbed instruction is written on the third edge after acceptance
	a_latency: assert property (@(posedge clk) disable iff (rst)
		$past(in_valid && !id_freeze, 3) && !$past(id_freeze, 2) && !$past(id_freeze)
		&& !id_freeze |-> wb_we)
		else $error("writeback not three cycles after acceptance");

	// Execute and writeback hold still under ex_freeze
	a_ex_hold: assert property (@(posedge clk) disable iff (rst)
		ex_freeze |-> !wb_we ##1 ($stable(wb_data) && $stable(operand_a)
			&& $stable(operand_b)))
		else $error("state moved during ex_freeze");

	// Saved operands stay put one edge after capture
	a_saved_hold: assert property (@(posedge clk) disable iff (rst)
		id_freeze && !ex_freeze |=> ##1 ($stable(operand_a) && $stable(operand_b)))
		else $error("saved operand changed");

	////////////////////////////////////////////////////////////////////////////
	// Forwarding muxes
	////////////////////////////////////////////////////////////////////////////

	a_mux_a: assert property (@(posedge clk) disable iff (rst)
		muxed_a == ((sel_a == opx_ctrl_pkg::opnd_ex_forw) ? ex_forw :
			(sel_a == opx_ctrl_pkg::opnd_wb_forw) ? wb_forw : rf_data_a))
		else $error("muxed_a does not match sel_a");

	a_mux_b: assert property (@(posedge clk) disable iff (rst)
		muxed_b == ((sel_b == opx_ctrl_pkg::opnd_ex_forw) ? ex_forw :
			(sel_b == opx_ctrl_pkg::opnd_wb_forw) ? wb_forw :
			(sel_b == opx_ctrl_pkg::opnd_imm) ? simm : rf_data_b))
		else $error("muxed_b does not match sel_b");

endmodule

bind opx_core opx_assert u_assert (.*);

/* tb_opx_core.sv */
// Operand path testbench
// LFSR stimulus with freezes, reference register model and writeback checks

`timescale 1ns/1ps

module tb_opx_core;

	// Instructions issued over the whole run, used by the watchdog
	localparam int num_instr = 63;

	logic                    clk;
	logic                    rst;
	logic                    id_freeze;
	logic                    ex_freeze;
	logic                    in_valid;
	opx_isa_pkg::alu_op_e    in_op;
	logic                    in_use_imm;
	opx_isa_pkg::reg_addr_t  in_rd;
	opx_isa_pkg::reg_addr_t  in_ra;
	opx_isa_pkg::reg_addr_t  in_rb;
	opx_isa_pkg::data_t      in_imm;
	logic                    wb_we;
	opx_isa_pkg::reg_addr_t  wb_rd;
	opx_isa_pkg::data_t      wb_data;

	// Reference state and expected writebacks in program order
	opx_isa_pkg::data_t      ref_regs [8];
	opx_isa_pkg::reg_addr_t  exp_rd_q [$];
	opx_isa_pkg::data_t      exp_data_q [$];
	logic [15:0]             lfsr;
	int                      errors;
	int                      accepted;
	int                      written;

	opx_core UUT (.*);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR with taps 16 14 13 11
	// Stepped once for every bit taken
	function automatic logic [31:0] get_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Hold the instruction through nf frozen cycles and then let it be accepted
	task automatic send(input opx_isa_pkg::alu_op_e op, input logic use_imm,
		input opx_isa_pkg::reg_addr_t rd, input opx_isa_pkg::reg_addr_t ra,
		input opx_isa_pkg::reg_addr_t rb, input opx_isa_pkg::data_t imm,
		input int nf, input logic use_ex);
		logic [31:0] r;
		for (int i = 0; i <= nf; i++) begin
			r = get_bits(1);
			@(posedge clk);
			in_valid   <= 1'b1;
			in_op      <= op;
			in_use_imm <= use_imm;
			in_rd      <= rd;
			in_ra      <= ra;
			in_rb      <= rb;
			in_imm     <= imm;
			id_freeze  <= (i < nf);
			ex_freeze  <= (i < nf) && use_ex && r[0];
		end
	endtask

	task automatic bubble();
		@(posedge clk);
		in_valid  <= 1'b0;
		id_freeze <= 1'b0;
		ex_freeze <= 1'b0;
	endtask

	task automatic rand_instr(input int nf, input logic use_ex);
		logic [31:0] op;
		logic [31:0] f;
		logic [31:0] imm;
		op  = get_bits(3);
		f   = get_bits(10);
		imm = get_bits(32);
		send(opx_isa_pkg::alu_op_e'(op[2:0]), f[9], f[8:6], f[5:3], f[2:0], imm,
			nf, use_ex);
	endtask

	// ALU behaviour as the operation list defines it
	function automatic opx_isa_pkg::data_t alu_model(input opx_isa_pkg::alu_op_e op,
		input opx_isa_pkg::data_t a, input opx_isa_pkg::data_t b);
		case (op)
			opx_isa_pkg::alu_add: alu_model = a + b;
			opx_isa_pkg::alu_sub: alu_model = a - b;
			opx_isa_pkg::alu_and: alu_model = a & b;
			opx_isa_pkg::alu_or:  alu_model = a | b;
			opx_isa_pkg::alu_xor: alu_model = a ^ b;
			opx_isa_pkg::alu_sll: alu_model = a << b[4:0];
			opx_isa_pkg::alu_srl: alu_model = a >> b[4:0];
			default:              alu_model = b;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model and writeback compare
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		opx_isa_pkg::data_t b;
		opx_isa_pkg::data_t res;
		if (!rst) begin
			// Accepted edge runs the instruction in program order
			if (in_valid && !id_freeze) begin
				b = in_use_imm ? in_imm : ref_regs[in_rb];
				res = alu_model(in_op, ref_regs[in_ra], b);
				ref_regs[in_rd] = res;
				exp_rd_q.push_back(in_rd);
				exp_data_q.push_back(res);
				accepted++;
			end
			if (wb_we) begin
				written++;
				if (exp_rd_q.size() == 0) begin
					$display("Writeback at %0t with no instruction outstanding", $time);
					errors++;
				end else if (wb_rd != exp_rd_q[0] || wb_data != exp_data_q[0]) begin
					$display("[FAIL] %0t: wrote r%0d=%h, expected r%0d=%h", $time,
						wb_rd, wb_data, exp_rd_q[0], exp_data_q[0]);
					errors++;
					void'(exp_rd_q.pop_front());
					void'(exp_data_q.pop_front());
				end else begin
					void'(exp_rd_q.pop_front());
					void'(exp_data_q.pop_front());
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		#(num_instr * 12 * 4);
		$display("Watchdog expired before all writebacks completed");
		$display("Simulation FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		clk        = 1'b0;
		rst        = 1'b1;
		id_freeze  = 1'b0;
		ex_freeze  = 1'b0;
		in_valid   = 1'b0;
		in_op      = opx_isa_pkg::alu_add;
		in_use_imm = 1'b0;
		in_rd      = '0;
		in_ra      = '0;
		in_rb      = '0;
		in_imm     = '0;
		lfsr       = 16'd78;
		errors     = 0;
		accepted   = 0;
		written    = 0;
		for (int i = 0; i < 8; i++)
			ref_regs[i] = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		for (int i = 0; i < 8; i++) begin
			if (UUT.u_regfile.regs[i] != '0) begin
				$display("[FAIL] %0t: r%0d not zero after reset", $time, i);
				errors++;
			end
		end

		// First result is the immediate itself
		send(opx_isa_pkg::alu_add, 1'b1, 3'd2, 3'd0, 3'd0, 32'h1234_5678, 0, 1'b0);
		repeat (5) bubble();

		// All eight operations without freezes
		for (int i = 0; i < 16; i++) begin
			r = get_bits(32);
			send(opx_isa_pkg::alu_op_e'(i % 8), r[31], r[2:0], r[5:3], r[8:6],
				r, 0, 1'b0);
		end

		// Dependences at distance 1, 2 and 3
		for (int d = 1; d <= 3; d++) begin
			r = get_bits(32);
			send(opx_isa_pkg::alu_add, 1'b1, 3'd5, 3'd1, 3'd0, r, 0, 1'b0);
			repeat (d - 1) bubble();
			send(opx_isa_pkg::alu_add, 1'b0, 3'd6, 3'd5, 3'd5, '0, 0, 1'b0);
		end

		// id_freeze bursts alone and then with ex_freeze inside
		for (int i = 0; i < 20; i++) begin
			r = get_bits(2);
			rand_instr(r[1:0], 1'b0);
		end
		for (int i = 0; i < 20; i++) begin
			r = get_bits(2);
			rand_instr(r[1:0] + 1, 1'b1);
		end

		bubble();
		while (exp_rd_q.size() != 0)
			bubble();
		repeat (4) bubble();
		if (written != accepted) begin
			$display("Writeback count %0d differs from accepted count %0d",
				written, accepted);
			errors++;
		end

		$display("Accepted %0d, written %0d, errors %0d", accepted, written, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+.
opx_isa_pkg.sv
opx_ctrl_pkg.sv
opx_decode.sv
opx_regfile.sv
opx_operand_mux.sv
opx_execute.sv
opx_core.sv
opx_assert.sv
tb_opx_core.sv

/* Makefile */
# Verilator build and run of the operand path testbench

sim:
	verilator --binary --assert -f build.f --top-module tb_opx_core -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
